/* design/ems_io_decoder.sv */
// EMS I/O decoder
// Qualifies CPU bus cycles, drives the DMA chip selects and port strobes,
// and turns EMS port writes into registered slot commands
`timescale 1ns/1ps
`default_nettype none

module ems_io_decoder
    import ems_ports_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  cpu_bus_t     bus_i,
    input  logic         ems_enabled_i,
    output logic         dma_chip_select_n_o,
    output logic         dma_page_chip_select_n_o,
    output port_access_t access_o,
    output ems_write_t   ems_write_o,
    output logic         mem_cycle_o,
    output page_addr_t   page_addr_o
);

    logic        io_request;
    logic        io_cycle;
    logic        ems_port_hit;
    logic        lpt_port_hit;
    logic        ems_port_write;
    logic        data_disable;
    logic        data_map;
    logic        cmd_strobe;
    slot_index_t cmd_index;
    ems_map_t    cmd_map;
    logic        cmd_enable;

    assign io_request = ~bus_i.io_read_n | ~bus_i.io_write_n;
    assign io_cycle   = io_request & ~bus_i.address_enable_n;

    // DMA controller at 000h..01Fh, page register at 080h..09Fh
    assign dma_chip_select_n_o      = ~(io_cycle && bus_i.address[9:5] == DMA_CTRL_SEL);
    assign dma_page_chip_select_n_o = ~(io_cycle && bus_i.address[9:5] == DMA_PAGE_SEL);

    // EMS registers at 260h..263h
    assign ems_port_hit = bus_i.address[15:2] == EMS_PORT_BASE[15:2];
    assign lpt_port_hit = bus_i.address[15:0] == LPT_DATA_PORT;

    always_comb begin
        access_o.ems_read  = ems_enabled_i & ~bus_i.address_enable_n
                             & ~bus_i.io_read_n & ems_port_hit;
        access_o.lpt_read  = ~bus_i.address_enable_n & ~bus_i.io_read_n & lpt_port_hit;
        access_o.lpt_write = ~bus_i.address_enable_n & ~bus_i.io_write_n & lpt_port_hit;
    end

    // Writes reach the slots whether or not EMS read-back is enabled
    assign ems_port_write = ~bus_i.address_enable_n & ~bus_i.io_write_n & ems_port_hit;

    assign data_disable = bus_i.data == EMS_DISABLE_CODE;
    assign data_map     = bus_i.data < EMS_MAP_LIMIT;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            cmd_strobe <= 1'b0;
        end else begin
            // 80h..FEh leave the slot alone
            cmd_strobe <= ems_port_write & (data_disable | data_map);
        end
    end

    always_ff @(posedge clock) begin
        cmd_index <= bus_i.address[1:0];
        if (data_disable) begin
            cmd_map    <= 7'h7F;
            cmd_enable <= 1'b0;
        end else begin
            cmd_map    <= bus_i.data[6:0];
            cmd_enable <= 1'b1;
        end
    end

    always_comb begin
        ems_write_o.strobe = cmd_strobe;
        ems_write_o.index  = cmd_index;
        ems_write_o.map    = cmd_map;
        ems_write_o.enable = cmd_enable;
    end

    // Memory request with no I/O strobe active
    assign mem_cycle_o = ~io_request & (~bus_i.memory_read_n | ~bus_i.memory_write_n);
    assign page_addr_o = bus_i.address[19:14];

endmodule

`default_nettype wire

/* design/ems_page_slot.sv */
// EMS page slot
// One page mapping register with the hit detector for its 16 KB window
`timescale 1ns/1ps
`default_nettype none

module ems_page_slot
    import ems_ports_pkg::*;
#(
    parameter int SLOT = 0
) (
    input  logic        clock,
    input  logic        reset,
    input  ems_write_t  ems_write_i,
    input  logic        mem_cycle_i,
    input  page_addr_t  page_addr_i,
    input  window_sel_t window_sel_i,
    output slot_state_t state_o,
    output logic        hit_o
);

    localparam slot_index_t SLOT_INDEX = slot_index_t'(SLOT);

    logic [3:0] window_base;
    page_addr_t slot_page;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state_o <= '0;
        end else if (ems_write_i.strobe && ems_write_i.index == SLOT_INDEX) begin
            state_o.map    <= ems_write_i.map;
            state_o.enable <= ems_write_i.enable;
        end
    end

    // Settings 2 and 3 both select D0000h
    always_comb begin
        case (window_sel_i)
            2'd0:    window_base = WINDOW_BASE_A;
            2'd1:    window_base = WINDOW_BASE_C;
            default: window_base = WINDOW_BASE_D;
        endcase
    end

    // Slot k covers base + k * 16 KB
    assign slot_page = {window_base, SLOT_INDEX};
    assign hit_o     = mem_cycle_i & state_o.enable & (page_addr_i == slot_page);

endmodule

`default_nettype wire

/* design/ems_ports_pkg.sv */
// EMS and printer port definitions for the XT chipset block
// Widths, port addresses, window bases and the bus structs
`default_nettype none

package ems_ports_pkg;

    // Widths with a meaning
    typedef logic [19:0] cpu_addr_t;
    typedef logic [7:0]  cpu_data_t;
    typedef logic [5:0]  page_addr_t;
    typedef logic [6:0]  ems_map_t;
    typedef logic [1:0]  slot_index_t;
    typedef logic [1:0]  window_sel_t;

    localparam int EMS_SLOTS = 4;

    // I/O port addresses
    localparam logic [15:0] EMS_PORT_BASE = 16'h0260;
    localparam logic [15:0] LPT_DATA_PORT = 16'h0378;

    // High nibble of the EMS window base
    localparam logic [3:0] WINDOW_BASE_A = 4'hA;
    localparam logic [3:0] WINDOW_BASE_C = 4'hC;
    localparam logic [3:0] WINDOW_BASE_D = 4'hD;

    // EMS write data classes
    localparam cpu_data_t EMS_DISABLE_CODE = 8'hFF;
    localparam cpu_data_t EMS_MAP_LIMIT    = 8'h80;

    // Address bits 9..5 for the DMA chip selects
    localparam logic [4:0] DMA_CTRL_SEL = 5'b00000;
    localparam logic [4:0] DMA_PAGE_SEL = 5'b00100;

    localparam cpu_data_t READ_IDLE = 8'hFF;
    localparam cpu_data_t LPT_RESET = 8'hFF;

    typedef struct packed {
        cpu_addr_t address;
        cpu_data_t data;
        logic      io_read_n;
        logic      io_write_n;
        logic      memory_read_n;
        logic      memory_write_n;
        logic      address_enable_n;
    } cpu_bus_t;

    typedef struct packed {
        logic        strobe;
        slot_index_t index;
        ems_map_t    map;
        logic        enable;
    } ems_write_t;

    typedef struct packed {
        ems_map_t map;
        logic     enable;
    } slot_state_t;

    typedef struct packed {
        logic ems_read;
        logic lpt_read;
        logic lpt_write;
    } port_access_t;

endpackage

`default_nettype wire

/* design/ems_readback_unit.sv */
// EMS and printer read-back unit
// Holds the printer data latch and registers the byte returned to the CPU
`timescale 1ns/1ps
`default_nettype none

module ems_readback_unit
    import ems_ports_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  cpu_bus_t     bus_i,
    input  port_access_t access_i,
    input  slot_state_t  slots_i [EMS_SLOTS],
    output cpu_data_t    data_bus_out_o,
    output logic         data_valid_o
);

    cpu_data_t   lpt_data;
    slot_state_t read_slot;
    cpu_data_t   ems_byte;

    // Printer data latch
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            lpt_data <= LPT_RESET;
        end else if (access_i.lpt_write) begin
            lpt_data <= bus_i.data;
        end
    end

    // Slot picked by the low address bits
    assign read_slot = slots_i[bus_i.address[1:0]];

    always_comb begin
        if (read_slot.enable) begin
            ems_byte = {1'b0, read_slot.map};
        end else begin
            ems_byte = READ_IDLE;
        end
    end

    // EMS ports win over the printer port
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            data_bus_out_o <= '0;
            data_valid_o   <= 1'b0;
        end else if (access_i.ems_read) begin
            data_bus_out_o <= ems_byte;
            data_valid_o   <= 1'b1;
        end else if (access_i.lpt_read) begin
            data_bus_out_o <= lpt_data;
            data_valid_o   <= 1'b1;
        end else begin
            data_bus_out_o <= '0;
            data_valid_o   <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* design/xt_ems_ports.sv */
// XT chipset EMS and printer ports
// Packs the CPU bus and connects the decoder, four EMS page slots
// and the read-back unit
`timescale 1ns/1ps
`default_nettype none

module xt_ems_ports
    import ems_ports_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  cpu_addr_t            address_i,
    input  cpu_data_t            data_i,
    input  logic                 io_read_n_i,
    input  logic                 io_write_n_i,
    input  logic                 memory_read_n_i,
    input  logic                 memory_write_n_i,
    input  logic                 address_enable_n_i,
    input  logic                 ems_enabled_i,
    input  window_sel_t          ems_window_i,
    output logic                 dma_chip_select_n_o,
    output logic                 dma_page_chip_select_n_o,
    output logic [EMS_SLOTS-1:0] ems_hit_o,
    output cpu_data_t            data_bus_out_o,
    output logic                 data_valid_o
);

    cpu_bus_t     bus;
    port_access_t access;
    ems_write_t   ems_write;
    logic         mem_cycle;
    page_addr_t   page_addr;
    slot_state_t  slot_state [EMS_SLOTS];

    always_comb begin
        bus.address          = address_i;
        bus.data             = data_i;
        bus.io_read_n        = io_read_n_i;
        bus.io_write_n       = io_write_n_i;
        bus.memory_read_n    = memory_read_n_i;
        bus.memory_write_n   = memory_write_n_i;
        bus.address_enable_n = address_enable_n_i;
    end

    ems_io_decoder i_ems_io_decoder (
        .clock                    (clock),
        .reset                    (reset),
        .bus_i                    (bus),
        .ems_enabled_i            (ems_enabled_i),
        .dma_chip_select_n_o      (dma_chip_select_n_o),
        .dma_page_chip_select_n_o (dma_page_chip_select_n_o),
        .access_o                 (access),
        .ems_write_o              (ems_write),
        .mem_cycle_o              (mem_cycle),
        .page_addr_o              (page_addr)
    );

    for (genvar k = 0; k < EMS_SLOTS; k++) begin : g_slot
        ems_page_slot #(
            .SLOT (k)
        ) i_ems_page_slot (
            .clock        (clock),
            .reset        (reset),
            .ems_write_i  (ems_write),
            .mem_cycle_i  (mem_cycle),
            .page_addr_i  (page_addr),
            .window_sel_i (ems_window_i),
            .state_o      (slot_state[k]),
            .hit_o        (ems_hit_o[k])
        );
    end

    ems_readback_unit i_ems_readback_unit (
        .clock          (clock),
        .reset          (reset),
        .bus_i          (bus),
        .access_i       (access),
        .slots_i        (slot_state),
        .data_bus_out_o (data_bus_out_o),
        .data_valid_o   (data_valid_o)
    );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Builds the XT EMS ports testbench with Verilator and runs it.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module tb_xt_ems_ports \
    --Mdir obj_dir \
    -o sim_tb_xt_ems_ports \
    -f vlog.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_tb_xt_ems_ports
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0

/* tests/tb_xt_ems_ports.sv */
// Testbench for the XT EMS and printer ports
// Applies a table of bus steps and checks selects, hits and read-back data
`timescale 1ns/1ps
`default_nettype none

module tb_xt_ems_ports
    import ems_ports_pkg::*;
();

    localparam int          CLOCK_PERIOD    = 4;
    localparam int          RESET_CYCLES    = 3;
    localparam int          WATCHDOG_MARGIN = 40;
    localparam logic [15:0] LFSR_SEED       = 16'd26594;

    // Bus operations
    localparam logic [2:0] OP_IOW       = 3'd0;
    localparam logic [2:0] OP_IOR       = 3'd1;
    localparam logic [2:0] OP_MEMR      = 3'd2;
    localparam logic [2:0] OP_MEMW      = 3'd3;
    localparam logic [2:0] OP_IOW_NOAEN = 3'd4;
    localparam logic [2:0] OP_IO_MEM    = 3'd5;

    typedef struct packed {
        logic [2:0]  op;
        cpu_addr_t   address;
        cpu_data_t   data;
        logic        random_data;
        logic        ems_enabled;
        window_sel_t window;
        logic        exp_valid;
        logic [3:0]  exp_hit;
        logic [1:0]  exp_selects;
    } step_t;

    logic                 clock = 1'b0;
    logic                 reset;
    cpu_addr_t            address;
    cpu_data_t            data;
    logic                 io_read_n;
    logic                 io_write_n;
    logic                 memory_read_n;
    logic                 memory_write_n;
    logic                 address_enable_n;
    logic                 ems_enabled;
    window_sel_t          ems_window;
    logic                 dma_chip_select_n;
    logic                 dma_page_chip_select_n;
    logic [EMS_SLOTS-1:0] ems_hit;
    cpu_data_t            data_bus_out;
    logic                 data_valid;

    step_t       steps[$];
    string       step_names[$];
    logic        table_ready = 1'b0;
    logic [15:0] lfsr_state  = LFSR_SEED;

    // Reference model of the slots and the printer latch
    ems_map_t  model_map [EMS_SLOTS];
    logic      model_enable [EMS_SLOTS];
    cpu_data_t model_lpt;

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    xt_ems_ports i_xt_ems_ports (
        .clock                    (clock),
        .reset                    (reset),
        .address_i                (address),
        .data_i                   (data),
        .io_read_n_i              (io_read_n),
        .io_write_n_i             (io_write_n),
        .memory_read_n_i          (memory_read_n),
        .memory_write_n_i         (memory_write_n),
        .address_enable_n_i       (address_enable_n),
        .ems_enabled_i            (ems_enabled),
        .ems_window_i             (ems_window),
        .dma_chip_select_n_o      (dma_chip_select_n),
        .dma_page_chip_select_n_o (dma_page_chip_select_n),
        .ems_hit_o                (ems_hit),
        .data_bus_out_o           (data_bus_out),
        .data_valid_o             (data_valid)
    );

    task automatic add_step(input string name, input logic [2:0] op, input cpu_addr_t addr,
                            input cpu_data_t value, input int random_data, input int enabled,
                            input int window, input int exp_valid, input logic [3:0] exp_hit,
                            input logic [1:0] exp_selects);
        step_t s;
        s.op          = op;
        s.address     = addr;
        s.data        = value;
        s.random_data = (random_data != 0);
        s.ems_enabled = (enabled != 0);
        s.window      = window_sel_t'(window);
        s.exp_valid   = (exp_valid != 0);
        s.exp_hit     = exp_hit;
        s.exp_selects = exp_selects;
        steps.push_back(s);
        step_names.push_back(name);
    endtask

    // Columns: name, op, address, data, random, EMS enable, window,
    // valid, hits, {DMA select, page select}
    task automatic build_table();
        add_step("reset_ems_0", OP_IOR, 20'h00260, 8'h00, 0, 1, 0, 1, 4'h0, 2'b11);
        add_step("reset_ems_1", OP_IOR, 20'h00261, 8'h00, 0, 1, 0, 1, 4'h0, 2'b11);
        add_step("reset_ems_2", OP_IOR, 20'h00262, 8'h00, 0, 1, 0, 1, 4'h0, 2'b11);
        add_step("reset_ems_3", OP_IOR, 20'h00263, 8'h00, 0, 1, 0, 1, 4'h0, 2'b11);
        add_step("reset_lpt", OP_IOR, 20'h00378, 8'h00, 0, 1, 0, 1, 4'h0, 2'b11);
        add_step("reset_no_hit", OP_MEMR, 20'hA0000, 8'h00, 0, 1, 0, 0, 4'h0, 2'b11);
        add_step("map_write_0", OP_IOW, 20'h00260, 8'h00, 1, 1, 0, 0, 4'h0, 2'b11);
        add_step("map_write_1", OP_IOW, 20'h00261, 8'h00, 1, 1, 0, 0, 4'h0, 2'b11);
        add_step("map_write_2", OP_IOW, 20'h00262, 8'h00, 1, 1, 0, 0, 4'h0, 2'b11);
        add_step("map_write_3", OP_IOW, 20'h00263, 8'h00, 1, 1, 0, 0, 4'h0, 2'b11);
        add_step("map_read_0", OP_IOR, 20'h00260, 8'h00, 0, 1, 0, 1, 4'h0, 2'b11);
        add_step("map_read_1", OP_IOR, 20'h00261, 8'h00, 0, 1, 0, 1, 4'h0, 2'b11);
        add_step("map_read_2", OP_IOR, 20'h00262, 8'h00, 0, 1, 0, 1, 4'h0, 2'b11);
        add_step("map_read_3", OP_IOR, 20'h00263, 8'h00, 0, 1, 0, 1, 4'h0, 2'b11);
        add_step("hit_a_0", OP_MEMR, 20'hA0000, 8'h00, 0, 1, 0, 0, 4'h1, 2'b11);
        add_step("hit_a_1", OP_MEMW, 20'hA4000, 8'h00, 0, 1, 0, 0, 4'h2, 2'b11);
        add_step("hit_a_2", OP_MEMR, 20'hA8000, 8'h00, 0, 1, 0, 0, 4'h4, 2'b11);
        add_step("hit_a_3", OP_MEMW, 20'hAC000, 8'h00, 0, 1, 0, 0, 4'h8, 2'b11);
        add_step("hit_c_1", OP_MEMR, 20'hC4000, 8'h00, 0, 1, 1, 0, 4'h2, 2'b11);
        add_step("hit_c_2", OP_MEMR, 20'hC8000, 8'h00, 0, 1, 1, 0, 4'h4, 2'b11);
        add_step("miss_c_old_a", OP_MEMR, 20'hA4000, 8'h00, 0, 1, 1, 0, 4'h0, 2'b11);
        add_step("hit_d_0", OP_MEMR, 20'hD0000, 8'h00, 0, 1, 2, 0, 4'h1, 2'b11);
        add_step("hit_d_3", OP_MEMW, 20'hDC000, 8'h00, 0, 1, 2, 0, 4'h8, 2'b11);
        add_step("hit_d3_2", OP_MEMR, 20'hD8000, 8'h00, 0, 1, 3, 0, 4'h4, 2'b11);
        add_step("disable_1", OP_IOW, 20'h00261, 8'hFF, 0, 1, 0, 0, 4'h0, 2'b11);
        add_step("disabled_read_1", OP_IOR, 20'h00261, 8'h00, 0, 1, 0, 1, 4'h0, 2'b11);
        add_step("disabled_miss_1", OP_MEMR, 20'hA4000, 8'h00, 0, 1, 0, 0, 4'h0, 2'b11);
        add_step("ignored_write_2", OP_IOW, 20'h00262, 8'h80, 0, 1, 0, 0, 4'h0, 2'b11);
        add_step("kept_read_2", OP_IOR, 20'h00262, 8'h00, 0, 1, 0, 1, 4'h0, 2'b11);
        add_step("kept_hit_2", OP_MEMR, 20'hA8000, 8'h00, 0, 1, 0, 0, 4'h4, 2'b11);
        add_step("ignored_write_1", OP_IOW, 20'h00261, 8'hFE, 0, 1, 0, 0, 4'h0, 2'b11);
        add_step("still_off_1", OP_IOR, 20'h00261, 8'h00, 0, 1, 0, 1, 4'h0, 2'b11);
        add_step("off_read_0", OP_IOR, 20'h00260, 8'h00, 0, 0, 0, 0, 4'h0, 2'b11);
        add_step("off_write_3", OP_IOW, 20'h00263, 8'h15, 0, 0, 0, 0, 4'h0, 2'b11);
        add_step("on_read_3", OP_IOR, 20'h00263, 8'h00, 0, 1, 0, 1, 4'h0, 2'b11);
        add_step("io_in_window", OP_IO_MEM, 20'hDC100, 8'h00, 0, 1, 2, 0, 4'h0, 2'b11);
        add_step("mem_in_window", OP_MEMR, 20'hDC100, 8'h00, 0, 1, 2, 0, 4'h8, 2'b11);
        add_step("lpt_write", OP_IOW, 20'h00378, 8'hA5, 0, 1, 0, 0, 4'h0, 2'b11);
        add_step("lpt_read", OP_IOR, 20'h00378, 8'h00, 0, 1, 0, 1, 4'h0, 2'b11);
        add_step("undecoded_read", OP_IOR, 20'h003F8, 8'h00, 0, 1, 0, 0, 4'h0, 2'b11);
        add_step("dma_ctrl_low", OP_IOR, 20'h00000, 8'h00, 0, 1, 0, 0, 4'h0, 2'b01);
        add_step("dma_ctrl_high", OP_IOW, 20'h0001F, 8'h00, 0, 1, 0, 0, 4'h0, 2'b01);
        add_step("dma_page_low", OP_IOR, 20'h00080, 8'h00, 0, 1, 0, 0, 4'h0, 2'b10);
        add_step("dma_page_high", OP_IOW, 20'h0009F, 8'h00, 0, 1, 0, 0, 4'h0, 2'b10);
        add_step("dma_above_ctrl", OP_IOR, 20'h00020, 8'h00, 0, 1, 0, 0, 4'h0, 2'b11);
        add_step("dma_above_page", OP_IOR, 20'h000A0, 8'h00, 0, 1, 0, 0, 4'h0, 2'b11);
        add_step("dma_mem_cycle", OP_MEMR, 20'h00010, 8'h00, 0, 1, 0, 0, 4'h0, 2'b11);
        add_step("dma_ctrl_aen", OP_IOW_NOAEN, 20'h00000, 8'h00, 0, 1, 0, 0, 4'h0, 2'b11);
        add_step("dma_page_aen", OP_IOW_NOAEN, 20'h00080, 8'h00, 0, 1, 0, 0, 4'h0, 2'b11);
    endtask

    // Fibonacci LFSR, taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    task automatic take_random_bits(input int count, output cpu_data_t value);
        value = '0;
        for (int b = 0; b < count; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[6:0], lfsr_state[0]};
        end
    endtask

    function automatic cpu_data_t model_read(input step_t s);
        logic ems_port;
        logic lpt_port;
        ems_port = s.address[15:0] >= 16'h0260 && s.address[15:0] <= 16'h0263;
        lpt_port = s.address[15:0] == 16'h0378;
        if (s.op != OP_IOR) begin
            return 8'h00;
        end
        if (ems_port && s.ems_enabled) begin
            if (model_enable[s.address[1:0]]) begin
                return {1'b0, model_map[s.address[1:0]]};
            end
            return 8'hFF;
        end
        if (lpt_port) begin
            return model_lpt;
        end
        return 8'h00;
    endfunction

    task automatic model_update(input step_t s);
        if (s.op == OP_IOW && s.address[15:0] >= 16'h0260 && s.address[15:0] <= 16'h0263) begin
            if (s.data == 8'hFF) begin
                model_map[s.address[1:0]]    = 7'h7F;
                model_enable[s.address[1:0]] = 1'b0;
            end else if (s.data < 8'h80) begin
                model_map[s.address[1:0]]    = s.data[6:0];
                model_enable[s.address[1:0]] = 1'b1;
            end
        end
        if (s.op == OP_IOW && s.address[15:0] == 16'h0378) begin
            model_lpt = s.data;
        end
    endtask

    task automatic drive_bus(input step_t s);
        address          <= s.address;
        data             <= s.data;
        ems_enabled      <= s.ems_enabled;
        ems_window       <= s.window;
        io_read_n        <= !(s.op == OP_IOR || s.op == OP_IO_MEM);
        io_write_n       <= !(s.op == OP_IOW || s.op == OP_IOW_NOAEN);
        memory_read_n    <= !(s.op == OP_MEMR || s.op == OP_IO_MEM);
        memory_write_n   <= !(s.op == OP_MEMW);
        address_enable_n <= (s.op == OP_IOW_NOAEN);
    endtask

    // Strobes released, enable and window held
    task automatic drive_idle();
        io_read_n        <= 1'b1;
        io_write_n       <= 1'b1;
        memory_read_n    <= 1'b1;
        memory_write_n   <= 1'b1;
        address_enable_n <= 1'b0;
    endtask

    task automatic check_value(input string name, input string what,
                               input cpu_data_t expected, input cpu_data_t actual);
        if (actual !== expected) begin
            $display("FAIL %s %s: expected %02h, actual %02h", name, what, expected, actual);
            $display("Errors found");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    initial begin
        step_t     step;
        cpu_data_t random_value;
        cpu_data_t expected_byte;
        reset            <= 1'b1;
        address          <= '0;
        data             <= '0;
        ems_enabled      <= 1'b1;
        ems_window       <= '0;
        drive_idle();
        for (int k = 0; k < EMS_SLOTS; k++) begin
            model_map[k]    = '0;
            model_enable[k] = 1'b0;
        end
        model_lpt = 8'hFF;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
        foreach (steps[i]) begin
            step = steps[i];
            if (step.random_data) begin
                take_random_bits(7, random_value);
                step.data = random_value;
            end
            @(posedge clock);
            drive_bus(step);
            // Selects and hits settle within the operation cycle
            @(negedge clock);
            check_value(step_names[i], "dma selects", {6'b0, step.exp_selects},
                        {6'b0, dma_chip_select_n, dma_page_chip_select_n});
            check_value(step_names[i], "ems hit", {4'b0, step.exp_hit}, {4'b0, ems_hit});
            @(posedge clock);
            drive_idle();
            @(negedge clock);
            expected_byte = step.exp_valid ? model_read(step) : 8'h00;
            check_value(step_names[i], "data valid", {7'b0, step.exp_valid}, {7'b0, data_valid});
            check_value(step_names[i], "read data", expected_byte, data_bus_out);
            model_update(step);
            @(posedge clock);
            drive_idle();
        end
        $display("No errors");
        $finish;
    end

    // Three cycles per step plus reset and a margin
    initial begin
        wait (table_ready);
        #((steps.size() * 3 + RESET_CYCLES + WATCHDOG_MARGIN) * CLOCK_PERIOD);
        $display("Watchdog expired before the stimulus table finished");
        $display("Errors found");
        $fatal(1, "Simulation timed out");
    end

endmodule

`default_nettype wire

/* tests/xt_ems_props.sv */
// Concurrent checks on the XT EMS ports outputs
// Bound into xt_ems_ports
`timescale 1ns/1ps
`default_nettype none

module xt_ems_props
    import ems_ports_pkg::*;
(
    input logic                 clock,
    input logic                 reset,
    input cpu_addr_t            address_i,
    input logic                 io_read_n_i,
    input logic                 address_enable_n_i,
    input logic                 ems_enabled_i,
    input logic                 dma_chip_select_n_i,
    input logic                 dma_page_chip_select_n_i,
    input logic [EMS_SLOTS-1:0] ems_hit_i,
    input logic                 data_valid_i
);

    logic ems_read_port;
    logic lpt_read_port;
    logic read_sampled;

    // Decoded port reads seen on the bus
    assign ems_read_port = ems_enabled_i && address_i[15:2] == EMS_PORT_BASE[15:2];
    assign lpt_read_port = address_i[15:0] == LPT_DATA_PORT;
    assign read_sampled  = !address_enable_n_i && !io_read_n_i
                           && (ems_read_port || lpt_read_port);

    valid_needs_read: assert property (@(posedge clock) disable iff (reset)
        data_valid_i |-> $past(read_sampled))
        else $error("data_valid_o high without a decoded read on the previous edge");

    // Windows never overlap
    single_hit: assert property (@(posedge clock) disable iff (reset)
        $onehot0(ems_hit_i))
        else $error("more than one EMS hit bit high");

    dma_selects_exclusive: assert property (@(posedge clock) disable iff (reset)
        dma_chip_select_n_i || dma_page_chip_select_n_i)
        else $error("both DMA chip selects low");

endmodule

bind xt_ems_ports xt_ems_props i_xt_ems_props (
    .clock                    (clock),
    .reset                    (reset),
    .address_i                (address_i),
    .io_read_n_i              (io_read_n_i),
    .address_enable_n_i       (address_enable_n_i),
    .ems_enabled_i            (ems_enabled_i),
    .dma_chip_select_n_i      (dma_chip_select_n_o),
    .dma_page_chip_select_n_i (dma_page_chip_select_n_o),
    .ems_hit_i                (ems_hit_o),
    .data_valid_i             (data_valid_o)
);

`default_nettype wire

/* vlog.f */
design/ems_ports_pkg.sv
design/ems_io_decoder.sv
design/ems_page_slot.sv
design/ems_readback_unit.sv
design/xt_ems_ports.sv
tests/xt_ems_props.sv
tests/tb_xt_ems_ports.sv
